//--- hw/mand_pkg.sv
package mand_pkg;

  // Q4.28 signed fixed point
  typedef logic signed [31:0] fix_t;
  typedef logic [15:0] iter_t;
  typedef logic [15:0] pix_idx_t;
  typedef logic [7:0]  dim_t;     // grid width or height

  localparam int FRAC_BITS  = 28;
  localparam int UNIT_LAT   = 3;             // every mult / addsub
  localparam int PIPE_DEPTH = 5 * UNIT_LAT;  // full iteration plus magnitude
  localparam int FLIGHT_W   = $clog2(PIPE_DEPTH + 1);

  localparam fix_t FIX_MAX      = fix_t'(32'h7fff_ffff);
  localparam fix_t FIX_MIN      = fix_t'(32'h8000_0000);
  localparam fix_t ESCAPE_LIMIT = fix_t'(32'h4000_0000);  // 4.0

  typedef struct packed {
    fix_t re;
    fix_t im;
  } cplx_t;

  typedef struct packed {
    pix_idx_t idx;
    iter_t    iter;   // iteration being computed
  } point_meta_t;

  typedef struct packed {
    cplx_t       c;
    cplx_t       z;
    point_meta_t meta;
  } pipe_in_t;

  typedef struct packed {
    cplx_t       c;
    cplx_t       z_next;
    fix_t        mag;     // |z_next|^2
    point_meta_t meta;
  } pipe_out_t;

  typedef struct packed {
    fix_t x_start;
    fix_t y_start;
    fix_t x_step;
    fix_t y_step;
    dim_t width;
    dim_t height;
  } window_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } ctrl_state_t;

  // clamp a wide intermediate into the fix_t range
  function automatic fix_t sat_fix(input logic signed [63:0] v);
    if (v > 64'(FIX_MAX))
      return FIX_MAX;
    else if (v < 64'(FIX_MIN))
      return FIX_MIN;
    else
      return fix_t'(v);
  endfunction

endpackage

//--- hw/mand_mult.sv
`timescale 1ns/10ps

module mand_mult (
  input  logic           clock,
  input  logic           rst_i,
  input  mand_pkg::fix_t a,
  input  mand_pkg::fix_t b,
  output mand_pkg::fix_t result
);
  import mand_pkg::*;

  logic signed [63:0] product;
  logic signed [63:0] product_shr;
  fix_t               lat_q [UNIT_LAT];

  assign product     = 64'(a) * 64'(b);
  assign product_shr = product >>> FRAC_BITS;  // drop extra fraction bits, truncating

  always_ff @(posedge clock or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < UNIT_LAT; i++)
      begin
        lat_q[i] <= '0;
      end
    end
    else
    begin
      lat_q[0] <= sat_fix(product_shr);
      for (int i = 1; i < UNIT_LAT; i++)
      begin
        lat_q[i] <= lat_q[i-1];
      end
    end
  end

  assign result = lat_q[UNIT_LAT-1];

endmodule

//--- hw/mand_addsub.sv
`timescale 1ns/10ps

module mand_addsub #(
  parameter bit SUBTRACT = 1'b0
) (
  input  logic           clock,
  input  logic           rst_i,
  input  mand_pkg::fix_t a,
  input  mand_pkg::fix_t b,
  output mand_pkg::fix_t result
);
  import mand_pkg::*;

  logic signed [63:0] exact;
  fix_t               lat_q [UNIT_LAT];

  // exact in 64 bits, clamped on the way into the chain
  assign exact = SUBTRACT ? (64'(a) - 64'(b)) : (64'(a) + 64'(b));

  always_ff @(posedge clock or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < UNIT_LAT; i++)
      begin
        lat_q[i] <= '0;
      end
    end
    else
    begin
      lat_q[0] <= sat_fix(exact);
      for (int i = 1; i < UNIT_LAT; i++)
      begin
        lat_q[i] <= lat_q[i-1];
      end
    end
  end

  assign result = lat_q[UNIT_LAT-1];

endmodule

//--- hw/mand_iter_pipe.sv
`timescale 1ns/10ps

module mand_iter_pipe (
  input  logic                clock,
  input  logic                rst_i,
  input  logic                in_valid,
  input  mand_pkg::pipe_in_t  in_data,
  output logic                out_valid,
  output mand_pkg::pipe_out_t out_data
);
  import mand_pkg::*;

  fix_t x_sq;
  fix_t y_sq;
  fix_t xy;
  fix_t re_diff;
  fix_t xy_dbl;
  fix_t zn_re;
  fix_t zn_im;
  fix_t zn_re_sq;
  fix_t zn_im_sq;
  fix_t mag;

  logic [PIPE_DEPTH-1:0] valid_q;
  cplx_t                 c_q    [PIPE_DEPTH];
  point_meta_t           meta_q [PIPE_DEPTH];
  cplx_t                 zn_q   [2*UNIT_LAT];  // z_next waits out stages 4 and 5

  // stage 1: x^2, y^2, xy
  mand_mult i_x_sq (.clock, .rst_i, .a(in_data.z.re), .b(in_data.z.re), .result(x_sq));
  mand_mult i_y_sq (.clock, .rst_i, .a(in_data.z.im), .b(in_data.z.im), .result(y_sq));
  mand_mult i_xy   (.clock, .rst_i, .a(in_data.z.re), .b(in_data.z.im), .result(xy));

  // stage 2
  mand_addsub #(.SUBTRACT(1'b1)) i_re_diff (.clock, .rst_i, .a(x_sq), .b(y_sq), .result(re_diff));
  mand_addsub #(.SUBTRACT(1'b0)) i_xy_dbl  (.clock, .rst_i, .a(xy), .b(xy), .result(xy_dbl));

  // stage 3: add c, which reaches tap 2*UNIT_LAT-1 just in time
  mand_addsub #(.SUBTRACT(1'b0)) i_zn_re
    (.clock, .rst_i, .a(re_diff), .b(c_q[2*UNIT_LAT-1].re), .result(zn_re));
  mand_addsub #(.SUBTRACT(1'b0)) i_zn_im
    (.clock, .rst_i, .a(xy_dbl), .b(c_q[2*UNIT_LAT-1].im), .result(zn_im));

  // stages 4 and 5: magnitude
  mand_mult i_zn_re_sq (.clock, .rst_i, .a(zn_re), .b(zn_re), .result(zn_re_sq));
  mand_mult i_zn_im_sq (.clock, .rst_i, .a(zn_im), .b(zn_im), .result(zn_im_sq));
  mand_addsub #(.SUBTRACT(1'b0)) i_mag (.clock, .rst_i, .a(zn_re_sq), .b(zn_im_sq), .result(mag));

  always_ff @(posedge clock or posedge rst_i)
  begin
    if (rst_i)
      valid_q <= '0;
    else
      valid_q <= {valid_q[PIPE_DEPTH-2:0], in_valid};
  end

  // identity of each point rides alongside the math
  always_ff @(posedge clock)
  begin
    c_q[0]    <= in_data.c;
    meta_q[0] <= in_data.meta;
    zn_q[0]   <= {zn_re, zn_im};
    for (int i = 1; i < PIPE_DEPTH; i++)
    begin
      c_q[i]    <= c_q[i-1];
      meta_q[i] <= meta_q[i-1];
    end
    for (int i = 1; i < 2*UNIT_LAT; i++)
    begin
      zn_q[i] <= zn_q[i-1];
    end
  end

  assign out_valid       = valid_q[PIPE_DEPTH-1];
  assign out_data.c      = c_q[PIPE_DEPTH-1];
  assign out_data.z_next = zn_q[2*UNIT_LAT-1];
  assign out_data.mag    = mag;
  assign out_data.meta   = meta_q[PIPE_DEPTH-1];

endmodule

//--- hw/mand_coord_gen.sv
`timescale 1ns/10ps

module mand_coord_gen (
  input  logic               clock,
  input  logic               rst_i,
  input  logic               load,
  input  mand_pkg::window_t  window,
  input  logic               take,
  output logic               has_point,
  output mand_pkg::cplx_t    point_c,
  output mand_pkg::pix_idx_t point_idx
);
  import mand_pkg::*;

  window_t  win_q;
  dim_t     col;
  dim_t     row;
  cplx_t    pos;

  // latched window and running coordinate
  always_ff @(posedge clock)
  begin
    if (load)
    begin
      win_q  <= window;
      pos.re <= window.x_start;
      pos.im <= window.y_start;
    end
    else if (take && has_point)
    begin
      if (col == win_q.width - 1'b1)
      begin
        pos.re <= win_q.x_start;  // back to row start
        pos.im <= sat_fix(64'(pos.im) + 64'(win_q.y_step));
      end
      else
        pos.re <= sat_fix(64'(pos.re) + 64'(win_q.x_step));
    end
  end

  always_ff @(posedge clock or posedge rst_i)
  begin
    if (rst_i)
    begin
      has_point <= 1'b0;
      col       <= '0;
      row       <= '0;
      point_idx <= '0;
    end
    else if (load)
    begin
      has_point <= (window.width != '0) && (window.height != '0);
      col       <= '0;
      row       <= '0;
      point_idx <= '0;
    end
    else if (take && has_point)
    begin
      point_idx <= point_idx + 1'b1;
      if (col == win_q.width - 1'b1)
      begin
        col <= '0;
        row <= row + 1'b1;
        if (row == win_q.height - 1'b1)
          has_point <= 1'b0;  // grid exhausted
      end
      else
        col <= col + 1'b1;
    end
  end

  assign point_c = pos;

endmodule

//--- hw/mand_control.sv
`timescale 1ns/10ps

module mand_control (
  input  logic                clock,
  input  logic                rst_i,
  input  logic                start,
  input  mand_pkg::iter_t     max_iter,
  input  logic                has_point,
  input  mand_pkg::cplx_t     point_c,
  input  mand_pkg::pix_idx_t  point_idx,
  output logic                load,
  output logic                take,
  output logic                in_valid,
  output mand_pkg::pipe_in_t  in_data,
  input  logic                out_valid,
  input  mand_pkg::pipe_out_t out_data,
  output logic                pixel_valid,
  output mand_pkg::pix_idx_t  pixel_idx,
  output mand_pkg::iter_t     pixel_count,
  output logic                busy,
  output logic                done
);
  import mand_pkg::*;

  ctrl_state_t         state;
  iter_t               max_iter_q;
  logic [FLIGHT_W-1:0] in_flight;
  logic [FLIGHT_W-1:0] in_flight_nxt;
  logic                retire;
  logic                recirc;
  logic                inject_new;

  assign retire = out_valid &&
                  ((out_data.mag > ESCAPE_LIMIT) || (out_data.meta.iter >= max_iter_q));
  assign recirc = out_valid && !retire;

  // recirculation owns the pipe input slot
  assign inject_new = (state == RUN) && has_point && !recirc;
  assign take       = inject_new;
  assign load       = start && !busy;
  assign in_valid   = recirc || inject_new;

  assign in_flight_nxt = in_flight + FLIGHT_W'(inject_new) - FLIGHT_W'(retire);

  always_comb
  begin
    if (recirc)
    begin
      in_data.c         = out_data.c;
      in_data.z         = out_data.z_next;
      in_data.meta.idx  = out_data.meta.idx;
      in_data.meta.iter = out_data.meta.iter + 1'b1;
    end
    else
    begin
      in_data.c         = point_c;
      in_data.z         = '0;   // fresh point starts at the origin
      in_data.meta.idx  = point_idx;
      in_data.meta.iter = iter_t'(1);
    end
  end

  always_ff @(posedge clock or posedge rst_i)
  begin
    if (rst_i)
    begin
      state       <= IDLE;
      max_iter_q  <= '0;
      in_flight   <= '0;
      pixel_valid <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
    end
    else
    begin
      pixel_valid <= retire;
      in_flight   <= in_flight_nxt;
      done        <= 1'b0;
      case (state)
        IDLE:
        begin
          busy <= 1'b0;   // falls the cycle after done
          if (load)
          begin
            state      <= RUN;
            busy       <= 1'b1;
            max_iter_q <= max_iter;
          end
        end
        RUN:
        begin
          if (!has_point)
            state <= DRAIN;
        end
        DRAIN:
        begin
          if (in_flight_nxt == '0)
          begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (retire)
    begin
      pixel_idx   <= out_data.meta.idx;
      pixel_count <= out_data.meta.iter;
    end
  end

endmodule

//--- hw/mand_engine.sv
`timescale 1ns/10ps

module mand_engine (
  input  logic               clock,
  input  logic               rst_i,
  input  logic               start,
  input  mand_pkg::window_t  window,
  input  mand_pkg::iter_t    max_iter,
  output logic               pixel_valid,
  output mand_pkg::pix_idx_t pixel_idx,
  output mand_pkg::iter_t    pixel_count,
  output logic               busy,
  output logic               done
);
  import mand_pkg::*;

  logic      has_point;
  cplx_t     point_c;
  pix_idx_t  point_idx;
  logic      load;
  logic      take;
  logic      in_valid;
  pipe_in_t  in_data;
  logic      out_valid;
  pipe_out_t out_data;

  mand_control i_control (
    .clock,
    .rst_i,
    .start,
    .max_iter,
    .has_point,
    .point_c,
    .point_idx,
    .load,
    .take,
    .in_valid,
    .in_data,
    .out_valid,
    .out_data,
    .pixel_valid,
    .pixel_idx,
    .pixel_count,
    .busy,
    .done
  );

  // raster walker
  mand_coord_gen i_coord_gen (
    .clock,
    .rst_i,
    .load,
    .window,
    .take,
    .has_point,
    .point_c,
    .point_idx
  );

  mand_iter_pipe i_iter_pipe (
    .clock,
    .rst_i,
    .in_valid,
    .in_data,
    .out_valid,
    .out_data
  );

endmodule

//--- tb/mand_engine_assertions.sv
`timescale 1ns/10ps

module mand_engine_assertions (
  input logic            clock,
  input logic            rst_i,
  input logic            start,
  input mand_pkg::iter_t max_iter,
  input logic            pixel_valid,
  input mand_pkg::iter_t pixel_count,
  input logic            busy,
  input logic            done
);
  import mand_pkg::*;

  iter_t max_iter_q;  // limit taken when a run is accepted
  int    fail_count;  // assertion failures so far

  always_ff @(posedge clock or posedge rst_i)
  begin
    if (rst_i)
      max_iter_q <= '0;
    else if (start && !busy)
      max_iter_q <= max_iter;
  end

  count_in_range: assert property (@(posedge clock) disable iff (rst_i)
    pixel_valid |-> (pixel_count != '0) && (pixel_count <= max_iter_q))
  else
  begin
    fail_count++;
    $error("pixel count %0d outside 1 to %0d", pixel_count, max_iter_q);
  end

  done_while_busy: assert property (@(posedge clock) disable iff (rst_i) done |-> busy)
  else
  begin
    fail_count++;
    $error("done pulse seen outside a run");
  end

  valid_while_busy: assert property (@(posedge clock) disable iff (rst_i) pixel_valid |-> busy)
  else
  begin
    fail_count++;
    $error("pixel strobe seen outside a run");
  end

endmodule

//--- tb/mand_engine_tb.sv
`timescale 1ns/10ps

module mand_engine_tb;
  import mand_pkg::*;

  localparam int NUM_TESTS = 7;
  localparam int TEST_GAP  = 200;  // setup and idle cycles per test

  typedef struct packed {
    window_t window;
    iter_t   max_iter;
    logic    rand_steps;
    logic    restart;     // second start pulse mid-run
    iter_t   expect_all;  // zero when only the model applies
  } test_row_t;

  logic      clock;
  logic      rst_i;
  logic      start;
  window_t   window;
  iter_t     max_iter;
  logic      pixel_valid;
  pix_idx_t  pixel_idx;
  iter_t     pixel_count;
  logic      busy;
  logic      done;

  test_row_t table_q [NUM_TESTS];
  int        exp_count [];
  bit        seen [];
  int        error_count;
  int        tests_failed;
  int        watchdog_cycles;
  logic      table_ready;

  mand_engine i_mand_engine (
    .clock,
    .rst_i,
    .start,
    .window,
    .max_iter,
    .pixel_valid,
    .pixel_idx,
    .pixel_count,
    .busy,
    .done
  );

  bind mand_engine mand_engine_assertions i_mand_engine_assertions (
    .clock(clock),
    .rst_i(rst_i),
    .start(start),
    .max_iter(max_iter),
    .pixel_valid(pixel_valid),
    .pixel_count(pixel_count),
    .busy(busy),
    .done(done)
  );

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic fix_t clamp_fix(input longint v);
    if (v > 64'sd2147483647)
      return fix_t'(32'h7fff_ffff);
    if (v < -64'sd2147483648)
      return fix_t'(32'h8000_0000);
    return fix_t'(v[31:0]);
  endfunction

  function automatic fix_t fx_mul(input fix_t a, input fix_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return clamp_fix(p >>> FRAC_BITS);  // truncate toward minus infinity
  endfunction

  function automatic fix_t fx_add(input fix_t a, input fix_t b);
    return clamp_fix(longint'(a) + longint'(b));
  endfunction

  function automatic fix_t fx_sub(input fix_t a, input fix_t b);
    return clamp_fix(longint'(a) - longint'(b));
  endfunction

  function automatic fix_t to_fix(input real r);
    return fix_t'($rtoi(r * 268435456.0));
  endfunction

  // escape-time reference for one point
  function automatic int escape_count(input fix_t c_re, input fix_t c_im, input iter_t max_it);
    fix_t zr;
    fix_t zi;
    fix_t nr;
    fix_t ni;
    fix_t mag;
    int   it;
    int   result;
    bit   escaped;
    zr = '0;
    zi = '0;
    result = int'(max_it);
    escaped = 1'b0;
    for (it = 1; it < int'(max_it); it++)
    begin
      if (!escaped)
      begin
        nr  = fx_add(fx_sub(fx_mul(zr, zr), fx_mul(zi, zi)), c_re);
        ni  = fx_add(fx_add(fx_mul(zr, zi), fx_mul(zr, zi)), c_im);
        mag = fx_add(fx_mul(nr, nr), fx_mul(ni, ni));
        if (mag > ESCAPE_LIMIT)
        begin
          result  = it;
          escaped = 1'b1;
        end
        zr = nr;
        zi = ni;
      end
    end
    return result;
  endfunction

  function automatic test_row_t make_row(input real xs, input real ys, input real xst,
                                         input real yst, input int w, input int h,
                                         input int mi, input bit rnd, input bit rst,
                                         input int all);
    test_row_t row;
    row.window.x_start = to_fix(xs);
    row.window.y_start = to_fix(ys);
    row.window.x_step  = to_fix(xst);
    row.window.y_step  = to_fix(yst);
    row.window.width   = dim_t'(w);
    row.window.height  = dim_t'(h);
    row.max_iter       = iter_t'(mi);
    row.rand_steps     = rnd;
    row.restart        = rst;
    row.expect_all     = iter_t'(all);
    return row;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      error_count++;
      $display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic build_table();
    int t;
    table_q[0] = make_row(-2.0, -1.5, 0.125, 0.1875, 24, 16, 32, 0, 0, 0);  // whole set
    table_q[1] = make_row(3.0, 1.0, 0.25, 0.25, 8, 4, 20, 0, 0, 1);         // far outside
    table_q[2] = make_row(-0.25, -0.25, 0.0625, 0.0625, 8, 8, 40, 0, 0, 40);  // cardioid
    table_q[3] = make_row(-2.0, -1.5, 0.5, 0.5, 4, 3, 1, 0, 0, 1);
    table_q[4] = make_row(-1.0, 0.0, 0.0, 0.0, 1, 1, 10, 0, 0, 10);           // period 2 orbit
    table_q[5] = make_row(-1.5, -1.0, 0.0, 0.0, 12, 10, 24, 1, 0, 0);
    table_q[6] = make_row(-2.0, -1.25, 0.1875, 0.25, 16, 10, 16, 0, 1, 0);
    for (t = 0; t < NUM_TESTS; t++)
    begin
      if (table_q[t].rand_steps)
      begin
        // steps between 1/16 and 1/8
        table_q[t].window.x_step = fix_t'(32'h0100_0000 + ($urandom & 32'h00ff_ffff));
        table_q[t].window.y_step = fix_t'(32'h0100_0000 + ($urandom & 32'h00ff_ffff));
      end
    end
  endtask

  // expected count per pixel index, coordinates walked in raster order
  task automatic build_expected(input test_row_t row);
    fix_t re;
    fix_t im;
    int   n;
    int   w;
    int   p;
    w  = int'(row.window.width);
    n  = w * int'(row.window.height);
    exp_count = new[n];
    seen = new[n];
    re = row.window.x_start;
    im = row.window.y_start;
    for (p = 0; p < n; p++)
    begin
      exp_count[p] = escape_count(re, im, row.max_iter);
      seen[p] = 1'b0;
      if (p % w == w - 1)
      begin
        re = row.window.x_start;
        im = fx_add(im, row.window.y_step);
      end
      else
        re = fx_add(re, row.window.x_step);
    end
  endtask

  task automatic check_idle(input int cycles_n, input string when);
    int k;
    for (k = 0; k < cycles_n; k++)
    begin
      @(posedge clock);
      #1;
      check_value({when, " pixel_valid"}, pixel_valid, 0);
      check_value({when, " busy"}, busy, 0);
      check_value({when, " done"}, done, 0);
    end
  endtask

  task automatic run_test(input int t);
    test_row_t row;
    int        n;
    int        got;
    int        cycles;
    int        limit;
    int        errs_before;
    int        idx;
    int        k;
    logic      got_done;
    row = table_q[t];
    errs_before = error_count;
    build_expected(row);
    n = exp_count.size();
    limit = n * int'(row.max_iter) * PIPE_DEPTH + TEST_GAP;
    check_idle(2, $sformatf("test %0d before start", t));
    window   = row.window;
    max_iter = row.max_iter;
    start    = 1'b1;
    @(posedge clock);
    #1;
    start = 1'b0;
    check_value($sformatf("test %0d busy after start", t), busy, 1);
    got = 0;
    cycles = 0;
    got_done = 1'b0;
    while (!got_done && cycles < limit)
    begin
      @(posedge clock);
      #1;
      cycles++;
      if (row.restart && cycles == 20)
      begin
        check_value($sformatf("test %0d busy at second start", t), busy, 1);
        start = 1'b1;
        window.width = 8'd3;  // must not be taken
        max_iter = iter_t'(1);
      end
      else if (row.restart && cycles == 21)
      begin
        start    = 1'b0;
        window   = row.window;
        max_iter = row.max_iter;
      end
      if (pixel_valid)
      begin
        got++;
        idx = int'(pixel_idx);
        if (idx >= n)
        begin
          error_count++;
          $display("test %0d: pixel index %0d lies outside the grid", t, idx);
        end
        else if (seen[idx])
        begin
          error_count++;
          $display("test %0d: pixel %0d was reported twice", t, idx);
        end
        else
        begin
          seen[idx] = 1'b1;
          check_value($sformatf("test %0d pixel %0d count", t, idx), pixel_count, exp_count[idx]);
          if (row.expect_all != '0)
            check_value($sformatf("test %0d pixel %0d table count", t, idx), pixel_count,
                        row.expect_all);
        end
      end
      if (done)
        got_done = 1'b1;
    end
    if (!got_done)
    begin
      error_count++;
      $display("test %0d: no done pulse within %0d cycles", t, limit);
    end
    check_value($sformatf("test %0d number of pixels", t), got, n);
    for (k = 0; k < n; k++)
    begin
      if (!seen[k])
      begin
        error_count++;
        $display("test %0d: pixel %0d was never reported", t, k);
      end
    end
    check_idle(10, $sformatf("test %0d after done", t));  // busy drops, no extra strobes
    $display("test %0d: %0d of %0d pixels, %0d errors", t, got, n, error_count - errs_before);
    if (error_count != errs_before)
      tests_failed++;
  endtask

  initial
  begin
    int t;
    rst_i        = 1'b1;
    start        = 1'b0;
    window       = '0;
    max_iter     = '0;
    error_count  = 0;
    tests_failed = 0;
    table_ready  = 1'b0;
    void'($urandom(32'h77fe));
    build_table();
    watchdog_cycles = 1000;
    for (t = 0; t < NUM_TESTS; t++)
      watchdog_cycles += int'(table_q[t].window.width) * int'(table_q[t].window.height) *
                         int'(table_q[t].max_iter) * PIPE_DEPTH + TEST_GAP;
    table_ready = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    rst_i = 1'b0;
    check_idle(8, "after reset");
    for (t = 0; t < NUM_TESTS; t++)
      run_test(t);
    if (i_mand_engine.i_mand_engine_assertions.fail_count != 0)
    begin
      $display("%0d assertion failures in the engine",
               i_mand_engine.i_mand_engine_assertions.fail_count);
      error_count += i_mand_engine.i_mand_engine_assertions.fail_count;
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
             NUM_TESTS - tests_failed, tests_failed, error_count);
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    wait (table_ready === 1'b1);
    repeat (watchdog_cycles) @(posedge clock);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- project.f
hw/mand_pkg.sv
hw/mand_mult.sv
hw/mand_addsub.sv
hw/mand_iter_pipe.sv
hw/mand_coord_gen.sv
hw/mand_control.sv
hw/mand_engine.sv
tb/mand_engine_assertions.sv
tb/mand_engine_tb.sv

//--- Makefile
# Verilator build and run for the Mandelbrot engine testbench

VERILATOR ?= verilator
TOP       ?= mand_engine_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTS PASSED

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
